// File: Makefile
VERILATOR ?= verilator
TOP ?= xbar_tb
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_MSG ?= Something failed

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) verification/xbar_tests.svh
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

# Rebuilt only when a source or the file list changes.
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status

check: run
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: files.f
+incdir+verification
logic/tl_pkg.sv
logic/rr_arbiter.sv
logic/pma_decode.sv
logic/xbar_ctrl.sv
logic/xbar_dp.sv
logic/xbar_top.sv
verification/xbar_tb.sv

// File: logic/pma_decode.sv
module pma_decode
    import tl_pkg::*;
(
    input  logic [addr_w-1:0] address,
    output logic [sel_w-1:0] chip_sel,
    output logic [addr_w-1:0] chip_addr,
    output logic fault
);

    logic [addr_w-1:0] offset;
    logic [addr_w-region_bits-1:0] region_idx;
    logic below_base;
    logic past_end;

    // Offset into the mapped window.
    assign offset = address - region_base;
    assign region_idx = offset[addr_w-1:region_bits];

    // Wraps on underflow, so the base check is separate.
    assign below_base = address < region_base;
    assign past_end = region_idx >= (addr_w - region_bits)'(n_slaves);
    assign fault = below_base | past_end;

    assign chip_sel = region_idx[sel_w-1:0];

    // Slave sees only its region offset.
    assign chip_addr = {{(addr_w - region_bits){1'b0}}, offset[region_bits-1:0]};

endmodule

// File: logic/rr_arbiter.sv
module rr_arbiter
    import tl_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic [n_masters-1:0] request,
    output logic [n_masters-1:0] grant
);

    logic [mst_w-1:0] ptr;
    logic [mst_w-1:0] idx;
    logic [mst_w-1:0] winner;
    logic found;

    // First requester at or after the pointer, wrapping around.
    always_comb begin
        grant = '0;
        winner = ptr;
        found = 1'b0;
        idx = ptr;
        for (int k = 0; k < n_masters; k++) begin
            idx = ptr + mst_w'(k);
            if (!found && request[idx]) begin
                grant[idx] = 1'b1;
                winner = idx;
                found = 1'b1;
            end
        end
    end

    // Winner drops to lowest priority.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (found) begin
            ptr <= winner + 1'b1;
        end
    end

    grant_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(grant)
    );

endmodule

// File: logic/tl_pkg.sv
package tl_pkg;

    // Crossbar geometry.
    localparam int n_masters = 4;
    localparam int n_slaves = 8;
    localparam int mst_w = $clog2(n_masters);
    localparam int sel_w = $clog2(n_slaves);

    // Bus widths.
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int mask_w = data_w / 8;
    localparam int src_w = 4;
    localparam int sink_w = 3;

    // Address map, one 4 KiB region per slave.
    localparam logic [addr_w-1:0] region_base = 32'h1000_0000;
    localparam int region_bits = 12;

    // Channel A opcodes.
    localparam logic [2:0] op_put_full = 3'd0;
    localparam logic [2:0] op_get = 3'd4;

    // Channel D opcodes.
    localparam logic [2:0] op_access_ack = 3'd0;
    localparam logic [2:0] op_access_ack_data = 3'd1;

    typedef struct packed {
        logic [2:0] opcode;
        logic [2:0] param;
        logic [2:0] size;
        logic [src_w-1:0] source;
        logic [addr_w-1:0] address;
        logic [mask_w-1:0] mask;
        logic [data_w-1:0] data;
        logic corrupt;
        logic valid;
    } tl_a_t;

    typedef struct packed {
        logic [2:0] opcode;
        logic [1:0] param;
        logic [2:0] size;
        logic [src_w-1:0] source;
        logic [sink_w-1:0] sink;
        logic denied;
        logic [data_w-1:0] data;
        logic corrupt;
        logic valid;
    } tl_d_t;

endpackage

// File: logic/xbar_ctrl.sv
module xbar_ctrl
    import tl_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic [n_masters-1:0] req,
    input  logic d_fire,
    output logic set_owner,
    output logic clr_owner
);

    typedef enum logic {
        st_idle,
        st_owned
    } state_t;

    state_t state;

    // Arbitrate as soon as anyone asks on an idle bus.
    assign set_owner = (state == st_idle) && (|req);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            clr_owner <= 1'b0;
        end else begin
            // Release one edge after the response handshake.
            clr_owner <= (state == st_owned) && d_fire;
            case (state)
                st_idle: begin
                    if (set_owner) begin
                        state <= st_owned;
                    end
                end
                st_owned: begin
                    if (clr_owner) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    owner_pulses_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(set_owner && clr_owner)
    );

    // A response only completes while someone owns the bus.
    fire_only_owned: assert property (
        @(posedge clk) disable iff (!rst_n)
        d_fire |-> state == st_owned
    );

endmodule

// File: logic/xbar_dp.sv
module xbar_dp
    import tl_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic set_owner,
    input  logic clr_owner,
    input  logic [n_masters-1:0] abt_grant,
    input  logic [sel_w-1:0] chip_sel,
    input  logic [addr_w-1:0] chip_addr,
    input  logic fault,
    output logic [addr_w-1:0] owner_addr,
    output logic d_fire,
    output logic [n_masters-1:0] req,
    input  tl_a_t m_a [n_masters],
    output logic [n_masters-1:0] m_a_ready,
    output tl_d_t m_d [n_masters],
    input  logic [n_masters-1:0] m_d_ready,
    output tl_a_t s_a [n_slaves],
    input  logic [n_slaves-1:0] s_a_ready,
    input  tl_d_t s_d [n_slaves],
    output logic [n_slaves-1:0] s_d_ready,
    output logic [n_masters-1:0] grant
);

    logic [n_masters-1:0] owner_bitmap;
    logic owner_valid;
    logic [n_masters-1:0] m_hit;
    logic [n_slaves-1:0] a_hit;
    logic [n_slaves-1:0] d_hit;
    logic [n_slaves-1:0] s_valid;
    logic a_taken;
    logic a_live;
    logic a_fire;
    logic own_a_ready;
    logic own_d_ready;
    logic [sel_w-1:0] sel_q;
    logic [sel_w-1:0] d_sel;
    logic fault_q;
    logic d_fault;
    logic flt_valid;
    logic flt_get;
    logic [2:0] flt_size;
    logic [src_w-1:0] flt_source;
    tl_a_t own_a;
    tl_a_t fwd_a;
    tl_d_t slv_d;
    tl_d_t flt_d;
    tl_d_t own_d;

    assign grant = owner_bitmap;
    assign m_hit = owner_valid ? owner_bitmap : '0;

    // Owner's A beat onto the shared bus.
    always_comb begin
        own_a = '0;
        for (int i = 0; i < n_masters; i++) begin
            own_a = own_a | (m_a[i] & {$bits(tl_a_t){m_hit[i]}});
            req[i] = m_a[i].valid;
        end
    end

    assign owner_addr = own_a.address;
    assign own_d_ready = |(m_d_ready & m_hit);

    // One request per ownership.
    assign a_live = own_a.valid & ~a_taken;

    // Hold the route once the request is gone from the A bus.
    assign d_sel = a_taken ? sel_q : chip_sel;
    assign d_fault = a_taken ? fault_q : fault;

    always_comb begin
        for (int j = 0; j < n_slaves; j++) begin
            a_hit[j] = owner_valid & ~fault & (chip_sel == sel_w'(j));
            d_hit[j] = owner_valid & ~d_fault & (d_sel == sel_w'(j));
        end
    end

    always_comb begin
        fwd_a = own_a;
        fwd_a.address = chip_addr;
        fwd_a.valid = a_live;
    end

    for (genvar j = 0; j < n_slaves; j++) begin : g_slave
        assign s_a[j] = tl_a_t'(fwd_a & {$bits(tl_a_t){a_hit[j]}});
        assign s_valid[j] = s_a[j].valid;
    end

    // Faulting beats are swallowed by the responder right away.
    assign own_a_ready = ~a_taken & (fault | (|(s_a_ready & a_hit)));
    assign m_a_ready = m_hit & {n_masters{own_a_ready}};
    assign a_fire = a_live & own_a_ready;

    always_comb begin
        slv_d = '0;
        for (int j = 0; j < n_slaves; j++) begin
            slv_d = slv_d | (s_d[j] & {$bits(tl_d_t){d_hit[j]}});
        end
    end

    // Denied response, zero data for a Get.
    always_comb begin
        flt_d = '0;
        flt_d.opcode = flt_get ? op_access_ack_data : op_access_ack;
        flt_d.size = flt_size;
        flt_d.source = flt_source;
        flt_d.denied = 1'b1;
        flt_d.valid = flt_valid;
    end

    assign own_d = d_fault ? flt_d : slv_d;
    assign d_fire = own_d.valid & own_d_ready;
    assign s_d_ready = d_hit & {n_slaves{own_d_ready}};

    for (genvar i = 0; i < n_masters; i++) begin : g_master
        assign m_d[i] = tl_d_t'(own_d & {$bits(tl_d_t){m_hit[i]}});
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner_bitmap <= '0;
            owner_valid <= 1'b0;
            a_taken <= 1'b0;
            flt_valid <= 1'b0;
        end else begin
            if (set_owner) begin
                owner_bitmap <= abt_grant;
                owner_valid <= 1'b1;
            end else if (clr_owner) begin
                owner_bitmap <= '0;
                owner_valid <= 1'b0;
            end
            if (set_owner) begin
                a_taken <= 1'b0;
            end else if (a_fire) begin
                a_taken <= 1'b1;
            end
            if (a_fire && fault) begin
                flt_valid <= 1'b1;
            end else if (d_fire) begin
                flt_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (a_fire) begin
            sel_q <= chip_sel;
            fault_q <= fault;
            flt_get <= own_a.opcode == op_get;
            flt_size <= own_a.size;
            flt_source <= own_a.source;
        end
    end

    no_beat_unowned: assert property (
        @(posedge clk) disable iff (!rst_n)
        !owner_valid |-> s_valid == '0
    );

    // Arbiter grant must name exactly one owner.
    single_owner: assert property (
        @(posedge clk) disable iff (!rst_n)
        owner_valid |-> $onehot(owner_bitmap)
    );

endmodule

// File: logic/xbar_top.sv
module xbar_top
    import tl_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  tl_a_t m_a [n_masters],
    output logic [n_masters-1:0] m_a_ready,
    output tl_d_t m_d [n_masters],
    input  logic [n_masters-1:0] m_d_ready,
    output tl_a_t s_a [n_slaves],
    input  logic [n_slaves-1:0] s_a_ready,
    input  tl_d_t s_d [n_slaves],
    output logic [n_slaves-1:0] s_d_ready,
    output logic [n_masters-1:0] grant
);

    logic [n_masters-1:0] req;
    logic [n_masters-1:0] abt_request;
    logic [n_masters-1:0] abt_grant;
    logic set_owner;
    logic clr_owner;
    logic d_fire;
    logic [addr_w-1:0] owner_addr;
    logic [sel_w-1:0] chip_sel;
    logic [addr_w-1:0] chip_addr;
    logic fault;

    // Arbiter only sees requests during the ownership pulse.
    assign abt_request = set_owner ? req : '0;

    xbar_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .d_fire    (d_fire),
        .set_owner (set_owner),
        .clr_owner (clr_owner)
    );

    rr_arbiter u_arbiter (
        .clk     (clk),
        .rst_n   (rst_n),
        .request (abt_request),
        .grant   (abt_grant)
    );

    pma_decode u_pma (
        .address   (owner_addr),
        .chip_sel  (chip_sel),
        .chip_addr (chip_addr),
        .fault     (fault)
    );

    xbar_dp u_dp (
        .clk        (clk),
        .rst_n      (rst_n),
        .set_owner  (set_owner),
        .clr_owner  (clr_owner),
        .abt_grant  (abt_grant),
        .chip_sel   (chip_sel),
        .chip_addr  (chip_addr),
        .fault      (fault),
        .owner_addr (owner_addr),
        .d_fire     (d_fire),
        .req        (req),
        .m_a        (m_a),
        .m_a_ready  (m_a_ready),
        .m_d        (m_d),
        .m_d_ready  (m_d_ready),
        .s_a        (s_a),
        .s_a_ready  (s_a_ready),
        .s_d        (s_d),
        .s_d_ready  (s_d_ready),
        .grant      (grant)
    );

endmodule

// File: verification/xbar_tests.svh
    localparam int rr_rounds = 2;
    localparam int hold_cycles = 5;

    function automatic tl_a_t make_a(input logic [2:0] op, input logic [addr_w-1:0] addr,
                                     input logic [data_w-1:0] data, input logic [src_w-1:0] src);
        tl_a_t a;
        a = '0;
        a.opcode = op;
        a.size = 3'd2;
        a.source = src;
        a.address = addr;
        a.mask = '1;
        a.data = data;
        a.valid = 1'b1;
        return a;
    endfunction

    function automatic int beat_total();
        int n;
        n = 0;
        for (int j = 0; j < n_slaves; j++) begin
            n += slv_beats[j];
        end
        return n;
    endfunction

    // Called right after a rising edge; returns on the accepting edge.
    task automatic send_a(input int m, input tl_a_t beat);
        int t;
        t = 0;
        m_a[m] <= beat;
        do begin
            @(posedge clk);
            t++;
            if (t > wait_limit) begin
                abort_run($sformatf("master %0d never saw its A beat accepted", m));
            end
        end while (!m_a_ready[m]);
        m_a[m] <= '0;
    endtask

    task automatic recv_d(input int m, output tl_d_t d);
        int t;
        t = 0;
        m_d_ready[m] <= 1'b1;
        do begin
            @(posedge clk);
            t++;
            if (t > wait_limit) begin
                abort_run($sformatf("master %0d never received a D beat", m));
            end
        end while (!(m_d[m].valid && m_d_ready[m]));
        d = m_d[m];
        m_d_ready[m] <= 1'b0;
    endtask

    task automatic transact(input int m, input tl_a_t beat, output tl_d_t d);
        send_a(m, beat);
        recv_d(m, d);
    endtask

    task automatic check_d(input tl_d_t d, input logic [2:0] op, input logic [src_w-1:0] src,
                           input logic [data_w-1:0] data, input logic denied);
        check_value("m_d.opcode", 64'(d.opcode), 64'(op));
        check_value("m_d.source", 64'(d.source), 64'(src));
        check_value("m_d.data", 64'(d.data), 64'(data));
        check_value("m_d.denied", 64'(d.denied), 64'(denied));
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        $display("test %s finished with %0d errors", name, errors - errors_before);
    endtask

    task automatic check_idle_outputs();
        check_value("grant", 64'(grant), 64'h0);
        for (int j = 0; j < n_slaves; j++) begin
            check_value($sformatf("s_a[%0d].valid", j), 64'(s_a[j].valid), 64'h0);
        end
        for (int i = 0; i < n_masters; i++) begin
            check_value($sformatf("m_d[%0d].valid", i), 64'(m_d[i].valid), 64'h0);
        end
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        repeat (3) @(posedge clk);
        check_idle_outputs();
        rst_n <= 1'b1;
        @(posedge clk);
        check_idle_outputs();
        finish_test("reset", e0);
    endtask

    task automatic rr_master(input int m);
        tl_d_t d;
        int s;
        for (int r = 0; r < rr_rounds; r++) begin
            s = (m + r) % n_slaves;
            transact(m, make_a(op_get, region_base + addr_w'(s << region_bits)
                     + addr_w'((m * 4 + r) * 4), '0, src_w'(m)), d);
            check_d(d, op_access_ack_data, src_w'(m), fill_word(s, m * 4 + r), 1'b0);
        end
    endtask

    task automatic watch_grants(input int n);
        logic [n_masters-1:0] prev;
        int t;
        prev = '0;
        t = 0;
        while (grant_order.size() < n) begin
            @(posedge clk);
            t++;
            if (t > wait_limit) begin
                abort_run("grant sequence did not complete");
            end
            for (int i = 0; i < n_masters; i++) begin
                if (prev == '0 && grant[i]) begin
                    grant_order.push_back(i);
                end
            end
            prev = grant;
        end
    endtask

    task automatic test_round_robin();
        int pending [n_masters];
        int expected [$];
        int ptr;
        int w;
        int e0;
        e0 = errors;
        grant_order.delete();
        // First pending requester at or after the pointer wins.
        ptr = 0;
        for (int i = 0; i < n_masters; i++) begin
            pending[i] = rr_rounds;
        end
        for (int n = 0; n < n_masters * rr_rounds; n++) begin
            w = -1;
            for (int k = 0; k < n_masters; k++) begin
                if (w < 0 && pending[(ptr + k) % n_masters] > 0) begin
                    w = (ptr + k) % n_masters;
                end
            end
            expected.push_back(w);
            pending[w]--;
            ptr = (w + 1) % n_masters;
        end
        fork
            rr_master(0);
            rr_master(1);
            rr_master(2);
            rr_master(3);
            watch_grants(n_masters * rr_rounds);
        join
        for (int n = 0; n < n_masters * rr_rounds; n++) begin
            check_value("grant order", 64'(grant_order[n]), 64'(expected[n]));
        end
        finish_test("round_robin", e0);
    endtask

    task automatic test_routing();
        tl_d_t d;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        logic [src_w-1:0] src;
        int beats0;
        int total0;
        int e0;
        e0 = errors;
        for (int m = 0; m < n_masters; m++) begin
            for (int s = 0; s < n_slaves; s++) begin
                data_rng = xorshift(data_rng);
                data = data_rng;
                data_rng = xorshift(data_rng);
                addr = region_base + addr_w'(s << region_bits) + {22'd0, data_rng[9:2], 2'b00};
                src = src_w'(m * 4 + s);
                beats0 = slv_beats[s];
                total0 = beat_total();
                transact(m, make_a(op_put_full, addr, data, src), d);
                check_d(d, op_access_ack, src, '0, 1'b0);
                transact(m, make_a(op_get, addr, '0, src), d);
                check_d(d, op_access_ack_data, src, data, 1'b0);
                check_value("slave beats", 64'(slv_beats[s] - beats0), 64'd2);
                check_value("all slave beats", 64'(beat_total() - total0), 64'd2);
            end
        end
        finish_test("routing", e0);
    endtask

    task automatic test_unmapped();
        tl_d_t d;
        logic [addr_w-1:0] bad [3];
        int total0;
        int e0;
        e0 = errors;
        bad[0] = 32'h0000_0ffc;
        bad[1] = region_base + addr_w'(n_slaves << region_bits);
        bad[2] = 32'hffff_fff0;
        for (int k = 0; k < 3; k++) begin
            total0 = beat_total();
            transact(1, make_a(op_put_full, bad[k], 32'hdead_beef, 4'h9), d);
            check_d(d, op_access_ack, 4'h9, '0, 1'b1);
            transact(1, make_a(op_get, bad[k], '0, 4'ha), d);
            check_d(d, op_access_ack_data, 4'ha, '0, 1'b1);
            check_value("all slave beats", 64'(beat_total() - total0), 64'd0);
        end
        finish_test("unmapped", e0);
    endtask

    task automatic test_back_pressure();
        logic [addr_w-1:0] addr;
        int beats0;
        int d_beats0;
        int t;
        int e0;
        e0 = errors;
        addr = region_base + addr_w'(3 << region_bits) + 32'h80;
        beats0 = slv_beats[3];
        d_beats0 = mst_d_beats[2];
        slv_stall[3] <= 1'b1;
        @(posedge clk);
        m_a[2] <= make_a(op_put_full, addr, 32'h0bad_cafe, 4'h5);
        // Arbitration cycle, the owner loads on the next edge.
        @(posedge clk);
        repeat (hold_cycles) begin
            @(posedge clk);
            check_value("grant", 64'(grant), 64'h4);
            check_value("m_a_ready", 64'(m_a_ready[2]), 64'h0);
        end
        slv_stall[3] <= 1'b0;
        t = 0;
        do begin
            @(posedge clk);
            t++;
            if (t > wait_limit) begin
                abort_run("stalled A beat was never accepted");
            end
        end while (!m_a_ready[2]);
        m_a[2] <= '0;
        t = 0;
        do begin
            @(posedge clk);
            t++;
            if (t > wait_limit) begin
                abort_run("no D beat offered to the stalled master");
            end
        end while (!m_d[2].valid);
        repeat (hold_cycles) begin
            @(posedge clk);
            check_value("grant", 64'(grant), 64'h4);
            check_value("m_d.valid", 64'(m_d[2].valid), 64'h1);
        end
        m_d_ready[2] <= 1'b1;
        @(posedge clk);
        check_d(m_d[2], op_access_ack, 4'h5, '0, 1'b0);
        m_d_ready[2] <= 1'b0;
        @(posedge clk);
        check_value("grant", 64'(grant), 64'h4);
        @(posedge clk);
        check_value("grant", 64'(grant), 64'h0);
        check_value("slave beats", 64'(slv_beats[3] - beats0), 64'd1);
        check_value("master D beats", 64'(mst_d_beats[2] - d_beats0), 64'd1);
        check_value("slave memory", 64'(slv_mem[3][32]), 64'h0bad_cafe);
        finish_test("back_pressure", e0);
    endtask

    task automatic run_tests();
        test_reset();
        test_round_robin();
        test_routing();
        test_unmapped();
        test_back_pressure();
    endtask

// File: verification/xbar_tb.sv
module xbar_tb
    import tl_pkg::*;
();

    localparam int wait_limit = 400;
    localparam int mem_words = 256;

    logic clk;
    logic rst_n;
    tl_a_t m_a [n_masters];
    logic [n_masters-1:0] m_a_ready;
    tl_d_t m_d [n_masters];
    logic [n_masters-1:0] m_d_ready;
    tl_a_t s_a [n_slaves];
    logic [n_slaves-1:0] s_a_ready = '0;
    tl_d_t s_d [n_slaves] = '{default: '0};
    logic [n_slaves-1:0] s_d_ready;
    logic [n_masters-1:0] grant;

    // Slave models, 1 KiB of words each.
    logic [data_w-1:0] slv_mem [n_slaves][mem_words];
    logic [n_slaves-1:0] slv_stall;
    logic [n_slaves-1:0] slv_busy;
    int slv_wait [n_slaves];
    tl_d_t slv_resp [n_slaves];
    int slv_beats [n_slaves];
    int mst_d_beats [n_masters];
    logic [31:0] delay_rng;
    logic [31:0] data_rng;
    int grant_order [$];
    int checks;
    int errors;
    int tests;

    xbar_top u_xbar_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .m_a       (m_a),
        .m_a_ready (m_a_ready),
        .m_d       (m_d),
        .m_d_ready (m_d_ready),
        .s_a       (s_a),
        .s_a_ready (s_a_ready),
        .s_d       (s_d),
        .s_d_ready (s_d_ready),
        .grant     (grant)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Fill pattern from the full bus address of the word.
    function automatic logic [data_w-1:0] fill_word(input int slave, input int word);
        return (region_base + addr_w'(slave << region_bits) + addr_w'(word * 4)) ^ 32'h5a5a_5a5a;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Something failed");
        $finish;
    endtask

    // Slaves answer after a random delay; masters count accepted D beats.
    always @(posedge clk) begin
        tl_d_t r;
        int w;
        if (!rst_n) begin
            delay_rng = 32'h7cb3c449;
            slv_busy <= '0;
            s_a_ready <= '0;
            for (int j = 0; j < n_slaves; j++) begin
                s_d[j] <= '0;
                slv_wait[j] <= 0;
                slv_beats[j] <= 0;
                for (int k = 0; k < mem_words; k++) begin
                    slv_mem[j][k] <= fill_word(j, k);
                end
            end
            for (int i = 0; i < n_masters; i++) begin
                mst_d_beats[i] <= 0;
            end
        end else begin
            for (int j = 0; j < n_slaves; j++) begin
                if (s_d[j].valid && s_d_ready[j]) begin
                    s_d[j] <= '0;
                    slv_busy[j] <= 1'b0;
                end else if (slv_busy[j] && !s_d[j].valid) begin
                    if (slv_wait[j] == 0) begin
                        s_d[j] <= slv_resp[j];
                    end else begin
                        slv_wait[j] <= slv_wait[j] - 1;
                    end
                end
                if (s_a[j].valid && s_a_ready[j]) begin
                    check_value("s_a.address", 64'(s_a[j].address >> region_bits), 64'h0);
                    w = int'(s_a[j].address[9:2]);
                    r = '0;
                    r.size = s_a[j].size;
                    r.source = s_a[j].source;
                    r.valid = 1'b1;
                    if (s_a[j].opcode == op_get) begin
                        r.opcode = op_access_ack_data;
                        r.data = slv_mem[j][w];
                    end else begin
                        r.opcode = op_access_ack;
                        for (int b = 0; b < mask_w; b++) begin
                            if (s_a[j].mask[b]) begin
                                slv_mem[j][w][8*b +: 8] <= s_a[j].data[8*b +: 8];
                            end
                        end
                    end
                    delay_rng = xorshift(delay_rng);
                    slv_resp[j] <= r;
                    slv_busy[j] <= 1'b1;
                    slv_wait[j] <= int'(delay_rng[1:0]);
                    slv_beats[j] <= slv_beats[j] + 1;
                end
                s_a_ready[j] <= !slv_stall[j] && !slv_busy[j] && !(s_a[j].valid && s_a_ready[j]);
            end
            for (int i = 0; i < n_masters; i++) begin
                if (m_d[i].valid && m_d_ready[i]) begin
                    mst_d_beats[i] <= mst_d_beats[i] + 1;
                end
            end
        end
    end

    `include "xbar_tests.svh"

    initial begin
        rst_n = 1'b0;
        m_d_ready = '0;
        slv_stall = '0;
        data_rng = 32'h7cb3c449;
        checks = 0;
        errors = 0;
        tests = 0;
        for (int i = 0; i < n_masters; i++) begin
            m_a[i] = '0;
        end
        run_tests();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
